// File: source/ascon_defs.svh
`ifndef ASCON_DEFS_SVH
`define ASCON_DEFS_SVH

// Datapath widths
`define ASCON_WORD_BITS        64
`define ASCON_KEY_BITS         128
`define ASCON_LEN_BITS         4
`define ASCON_BLOCK_BYTES      8

// Permutation round counts
`define ASCON_ROUNDS_A         12
`define ASCON_ROUNDS_B         6
`define ASCON_ROUNDS_PER_CYCLE 2

// Ascon-128 IV: k=128, r=64, a=12, b=6
`define ASCON_IV               64'h80400c0600000000

`endif

// File: source/asconAlgPkg.sv
`include "ascon_defs.svh"

package asconAlgPkg;

    // One 64-bit lane of the state, also the size of a data block
    typedef logic [`ASCON_WORD_BITS-1:0] laneT;

    // Five lanes, index 0 is x0 and sits in the most significant lane
    typedef laneT [0:4] permStateT;

    // Round index 0..11, values up to 15 fit
    typedef logic [3:0] roundIdxT;

    // Byte count of a block, 8 means full
    typedef logic [`ASCON_LEN_BITS-1:0] byteLenT;

    ////////////////////////////////////////////////////////////////////////////
    // Round constant
    ////////////////////////////////////////////////////////////////////////////

    // 0xF0, 0xE1, ... 0x4B for rounds 0 to 11
    function automatic logic [7:0] roundConstant(input roundIdxT idx);
        return 8'hF0 - 8'h0F * 8'(idx);
    endfunction

endpackage

// File: source/asconCtrlPkg.sv
package asconCtrlPkg;

    // Controller phases
    // Every state other than idle means a permutation of that phase is running,
    // and the next injection happens when the permutation reports done
    typedef enum logic [2:0] {
        stIdle,
        stInit,
        stAd,
        stText,
        stFinal
    } ctrlStateT;

endpackage

// File: source/asconRound.sv
`timescale 1ns/1ps

module asconRound (
    input  asconAlgPkg::permStateT stateIn,
    input  asconAlgPkg::roundIdxT  roundIdx,
    output asconAlgPkg::permStateT stateOut
);
    import asconAlgPkg::*;

    laneT x0, x1, x2, x3, x4;
    laneT t0, t1, t2, t3, t4;

    function automatic laneT rotr(input laneT v, input int unsigned n);
        return (v >> n) | (v << ($bits(laneT) - n));
    endfunction

    always_comb begin
        x0 = stateIn[0];
        x1 = stateIn[1];
        x2 = stateIn[2];
        x3 = stateIn[3];
        x4 = stateIn[4];

        // Constant addition on the low byte of x2
        x2[7:0] = x2[7:0] ^ roundConstant(roundIdx);

        // S-box layer, bit-sliced across the 64 columns
        x0 = x0 ^ x4;
        x4 = x4 ^ x3;
        x2 = x2 ^ x1;
        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;
        x0 = x0 ^ t1;
        x1 = x1 ^ t2;
        x2 = x2 ^ t3;
        x3 = x3 ^ t4;
        x4 = x4 ^ t0;
        x1 = x1 ^ x0;
        x0 = x0 ^ x4;
        x3 = x3 ^ x2;
        x2 = ~x2;

        // Linear diffusion, each lane with its own rotation pair
        stateOut[0] = x0 ^ rotr(x0, 19) ^ rotr(x0, 28);
        stateOut[1] = x1 ^ rotr(x1, 61) ^ rotr(x1, 39);
        stateOut[2] = x2 ^ rotr(x2, 1) ^ rotr(x2, 6);
        stateOut[3] = x3 ^ rotr(x3, 10) ^ rotr(x3, 17);
        stateOut[4] = x4 ^ rotr(x4, 7) ^ rotr(x4, 41);
    end

endmodule

// File: source/asconPermutation.sv
`timescale 1ns/1ps
`include "ascon_defs.svh"

module asconPermutation #(
    parameter int roundsPerCycle = `ASCON_ROUNDS_PER_CYCLE
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  asconAlgPkg::permStateT stateIn,
    input  asconAlgPkg::roundIdxT  startRound,
    output asconAlgPkg::permStateT stateOut,
    output logic                   done
);
    import asconAlgPkg::*;

    // Index one past the last round
    localparam roundIdxT roundEnd = roundIdxT'(`ASCON_ROUNDS_A);

    permStateT stateReg;
    roundIdxT  roundIdx;
    roundIdxT  baseIdx;
    logic      haveResult;
    logic      running;
    permStateT chain [0:roundsPerCycle];

    assign running  = (roundIdx < roundEnd);
    assign chain[0] = load ? stateIn : stateReg;
    assign baseIdx  = load ? startRound : roundIdx;

    // Unrolled rounds for one clock
    for (genvar g = 0; g < roundsPerCycle; g++) begin : g_round
        asconRound u_round (
            .stateIn (chain[g]),
            .roundIdx(baseIdx + roundIdxT'(g)),
            .stateOut(chain[g+1])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            roundIdx   <= roundEnd;
            haveResult <= 1'b0;
        end else if (load) begin
            roundIdx   <= startRound + roundIdxT'(roundsPerCycle);
            haveResult <= 1'b1;
        end else if (running) begin
            roundIdx <= roundIdx + roundIdxT'(roundsPerCycle);
        end
    end

    always_ff @(posedge clk) begin
        if (load || running) begin
            stateReg <= chain[roundsPerCycle];
        end
    end

    assign stateOut = stateReg;
    assign done     = haveResult && !running;

endmodule

// File: source/asconPadding.sv
`timescale 1ns/1ps
`include "ascon_defs.svh"

module asconPadding (
    input  asconAlgPkg::laneT    block,
    input  asconAlgPkg::byteLenT len,
    output asconAlgPkg::laneT    padded
);
    import asconAlgPkg::*;

    // Bytes are numbered from the MSB end of the lane
    always_comb begin
        for (int b = 0; b < `ASCON_BLOCK_BYTES; b++) begin
            if (b < len) begin
                padded[`ASCON_WORD_BITS-1-8*b -: 8] = block[`ASCON_WORD_BITS-1-8*b -: 8];
            end else if (b == len) begin
                // Pad bit right after the data
                padded[`ASCON_WORD_BITS-1-8*b -: 8] = 8'h80;
            end else begin
                padded[`ASCON_WORD_BITS-1-8*b -: 8] = 8'h00;
            end
        end
    end

endmodule

// File: source/asconController.sv
`timescale 1ns/1ps
`include "ascon_defs.svh"

module asconController (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         hasAd,
    input  logic                         enc,
    input  logic [`ASCON_KEY_BITS-1:0]   key,
    input  logic [`ASCON_KEY_BITS-1:0]   nonce,
    input  asconAlgPkg::byteLenT         adLen,
    input  asconAlgPkg::byteLenT         textLen,
    input  asconAlgPkg::laneT            adBlock,
    input  asconAlgPkg::laneT            textBlock,
    input  asconAlgPkg::laneT            padIn,
    input  asconAlgPkg::laneT            padOut,
    input  asconAlgPkg::permStateT       permState,
    input  logic                         permDone,
    output asconAlgPkg::laneT            selBlock,
    output asconAlgPkg::byteLenT         selLen,
    output logic                         load,
    output asconAlgPkg::permStateT       stateIn,
    output asconAlgPkg::roundIdxT        startRound,
    output logic                         read,
    output asconAlgPkg::laneT            outBlock,
    output logic                         outValid,
    output logic [`ASCON_KEY_BITS-1:0]   tag,
    output logic                         tagValid
);
    import asconAlgPkg::*;
    import asconCtrlPkg::*;

    localparam byteLenT  fullLen       = byteLenT'(`ASCON_BLOCK_BYTES);
    localparam roundIdxT longRunStart  = roundIdxT'(0);
    localparam roundIdxT shortRunStart = roundIdxT'(`ASCON_ROUNDS_A - `ASCON_ROUNDS_B);

    ctrlStateT                    state;
    ctrlStateT                    nextState;
    logic [`ASCON_KEY_BITS-1:0]   keyReg;
    laneT                         keyHi;
    laneT                         keyLo;
    logic                         adLast;
    logic                         useAd;
    logic                         doAd;
    logic                         doText;
    laneT                         rawOut;
    laneT                         textMask;
    permStateT                    s;

    assign {keyHi, keyLo} = keyReg;

    ////////////////////////////////////////////////////////////////////////////
    // Block selection for the input padding unit
    ////////////////////////////////////////////////////////////////////////////

    // AD is absorbed right after init, and after every full AD block
    assign useAd = ((state == stInit) && hasAd) || ((state == stAd) && !adLast);

    assign selBlock = useAd ? adBlock : textBlock;
    assign selLen   = useAd ? adLen : textLen;

    // Keep only the first textLen bytes of the output
    always_comb begin
        textMask = '0;
        for (int b = 0; b < `ASCON_BLOCK_BYTES; b++) begin
            if (b < textLen) begin
                textMask[`ASCON_WORD_BITS-1-8*b -: 8] = 8'hFF;
            end
        end
    end

    // Ciphertext when encrypting, plaintext when decrypting
    assign rawOut   = permState[0] ^ (enc ? padIn : textBlock);
    assign outBlock = rawOut & textMask;

    assign tag = {permState[3], permState[4]} ^ keyReg;

    ////////////////////////////////////////////////////////////////////////////
    // Phase FSM and state injection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        s          = permState;
        nextState  = state;
        load       = 1'b0;
        read       = 1'b0;
        outValid   = 1'b0;
        tagValid   = 1'b0;
        startRound = longRunStart;
        doAd       = 1'b0;
        doText     = 1'b0;

        case (state)
            stIdle: begin
                if (start) begin
                    load      = 1'b1;
                    s         = {laneT'(`ASCON_IV), key, nonce};
                    nextState = stInit;
                end
            end
            stInit: begin
                if (permDone) begin
                    s[3] = s[3] ^ keyHi;
                    s[4] = s[4] ^ keyLo;
                    if (useAd) begin
                        doAd = 1'b1;
                    end else begin
                        // Domain separation, no AD at all
                        s[4]   = s[4] ^ laneT'(1);
                        doText = 1'b1;
                    end
                end
            end
            stAd: begin
                if (permDone) begin
                    if (useAd) begin
                        doAd = 1'b1;
                    end else begin
                        s[4]   = s[4] ^ laneT'(1);
                        doText = 1'b1;
                    end
                end
            end
            stText: begin
                if (permDone) begin
                    doText = 1'b1;
                end
            end
            stFinal: begin
                if (permDone) begin
                    tagValid  = 1'b1;
                    nextState = stIdle;
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase

        // Absorb one padded AD block into x0
        if (doAd) begin
            read       = 1'b1;
            load       = 1'b1;
            s[0]       = s[0] ^ padIn;
            startRound = shortRunStart;
            nextState  = stAd;
        end

        // Text block: x0 becomes the ciphertext side, padded
        if (doText) begin
            read     = 1'b1;
            outValid = 1'b1;
            load     = 1'b1;
            s[0]     = enc ? (s[0] ^ padIn) : (s[0] ^ padOut);
            if (textLen == fullLen) begin
                startRound = shortRunStart;
                nextState  = stText;
            end else begin
                // Last text block, go straight to finalization
                s[1]       = s[1] ^ keyHi;
                s[2]       = s[2] ^ keyLo;
                startRound = longRunStart;
                nextState  = stFinal;
            end
        end
    end

    assign stateIn = s;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= stIdle;
            adLast <= 1'b0;
        end else begin
            state <= nextState;
            if (doAd) begin
                adLast <= (adLen != fullLen);
            end
        end
    end

    // Key is sampled once per message
    always_ff @(posedge clk) begin
        if ((state == stIdle) && start) begin
            keyReg <= key;
        end
    end

endmodule

// File: source/asconTop.sv
`timescale 1ns/1ps
`include "ascon_defs.svh"

module asconTop (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         hasAd,
    input  logic                         enc,
    input  logic [`ASCON_KEY_BITS-1:0]   key,
    input  logic [`ASCON_KEY_BITS-1:0]   nonce,
    input  asconAlgPkg::laneT            adBlock,
    input  asconAlgPkg::byteLenT         adLen,
    input  asconAlgPkg::laneT            textBlock,
    input  asconAlgPkg::byteLenT         textLen,
    output logic                         read,
    output asconAlgPkg::laneT            outBlock,
    output logic                         outValid,
    output logic [`ASCON_KEY_BITS-1:0]   tag,
    output logic                         tagValid
);
    import asconAlgPkg::*;

    laneT      selBlock;
    byteLenT   selLen;
    laneT      paddedIn;
    laneT      paddedOut;
    logic      load;
    permStateT stateIn;
    roundIdxT  startRound;
    permStateT permState;
    logic      permDone;

    asconController u_controller (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .hasAd     (hasAd),
        .enc       (enc),
        .key       (key),
        .nonce     (nonce),
        .adLen     (adLen),
        .textLen   (textLen),
        .adBlock   (adBlock),
        .textBlock (textBlock),
        .padIn     (paddedIn),
        .padOut    (paddedOut),
        .permState (permState),
        .permDone  (permDone),
        .selBlock  (selBlock),
        .selLen    (selLen),
        .load      (load),
        .stateIn   (stateIn),
        .startRound(startRound),
        .read      (read),
        .outBlock  (outBlock),
        .outValid  (outValid),
        .tag       (tag),
        .tagValid  (tagValid)
    );

    asconPermutation #(
        .roundsPerCycle(`ASCON_ROUNDS_PER_CYCLE)
    ) u_permutation (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .stateIn   (stateIn),
        .startRound(startRound),
        .stateOut  (permState),
        .done      (permDone)
    );

    // AD or plaintext going into the state
    asconPadding u_padIn (
        .block (selBlock),
        .len   (selLen),
        .padded(paddedIn)
    );

    // Decrypted text re-padded for the x0 update
    asconPadding u_padOut (
        .block (outBlock),
        .len   (textLen),
        .padded(paddedOut)
    );

endmodule

// File: tests/asconModelPkg.sv
`include "ascon_defs.svh"

package asconModelPkg;

    typedef logic [`ASCON_WORD_BITS-1:0] mLaneT;
    typedef mLaneT blockQ [$];
    // x0 in the most significant lane
    typedef logic [0:4][`ASCON_WORD_BITS-1:0] mStateT;

    localparam mLaneT initWord = 64'h80400c0600000000;

    // Ascon S-box in table order, entry 0 first
    // Column value has x0 as its MSB
    localparam logic [159:0] sboxTable = {
        5'h04, 5'h0b, 5'h1f, 5'h14, 5'h1a, 5'h15, 5'h09, 5'h02,
        5'h1b, 5'h05, 5'h08, 5'h12, 5'h1d, 5'h03, 5'h06, 5'h1c,
        5'h1e, 5'h13, 5'h07, 5'h0e, 5'h00, 5'h0d, 5'h11, 5'h18,
        5'h10, 5'h0c, 5'h01, 5'h19, 5'h16, 5'h0a, 5'h0f, 5'h17
    };

    function automatic mLaneT rotr(input mLaneT v, input int n);
        return (v >> n) | (v << (64 - n));
    endfunction

    function automatic mStateT modelRound(input mStateT s, input int r);
        mStateT     t;
        logic [4:0] col;
        s[2][7:0] = s[2][7:0] ^ 8'((15 - r) * 16 + r);
        for (int b = 0; b < 64; b++) begin
            col = {s[0][b], s[1][b], s[2][b], s[3][b], s[4][b]};
            col = sboxTable[5 * (31 - int'(col)) +: 5];
            {t[0][b], t[1][b], t[2][b], t[3][b], t[4][b]} = col;
        end
        s[0] = t[0] ^ rotr(t[0], 19) ^ rotr(t[0], 28);
        s[1] = t[1] ^ rotr(t[1], 61) ^ rotr(t[1], 39);
        s[2] = t[2] ^ rotr(t[2], 1) ^ rotr(t[2], 6);
        s[3] = t[3] ^ rotr(t[3], 10) ^ rotr(t[3], 17);
        s[4] = t[4] ^ rotr(t[4], 7) ^ rotr(t[4], 41);
        return s;
    endfunction

    // Last rounds of the 12 round schedule
    function automatic mStateT permute(input mStateT s, input int rounds);
        for (int r = 12 - rounds; r < 12; r++) begin
            s = modelRound(s, r);
        end
        return s;
    endfunction

    function automatic mLaneT keepMask(input int len);
        return (len == 0) ? '0 : (~mLaneT'(0) << (64 - 8 * len));
    endfunction

    function automatic mLaneT padBit(input int len);
        return (len >= 8) ? '0 : (mLaneT'(8'h80) << (56 - 8 * len));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Whole message, every block but the last of a phase is full
    ////////////////////////////////////////////////////////////////////////////

    task automatic aeadModel(input logic encMode, input logic [127:0] key, nonce,
            input blockQ ad, input int adLast, input blockQ txt, input int txtLast,
            output blockQ res, output logic [127:0] tag);
        mStateT s;
        mLaneT  x;
        int     len;
        res = {};
        s = {initWord, key, nonce};
        s = permute(s, 12);
        s[3] = s[3] ^ key[127:64];
        s[4] = s[4] ^ key[63:0];
        foreach (ad[i]) begin
            len  = (i == ad.size() - 1) ? adLast : 8;
            s[0] = s[0] ^ (ad[i] & keepMask(len)) ^ padBit(len);
            s    = permute(s, 6);
        end
        s[4] = s[4] ^ 64'd1;
        foreach (txt[i]) begin
            len = (i == txt.size() - 1) ? txtLast : 8;
            x   = (s[0] ^ txt[i]) & keepMask(len);
            res.push_back(x);
            // Ciphertext bytes end up in x0 in both directions
            if (encMode) begin
                s[0] = (s[0] & ~keepMask(len)) | x;
            end else begin
                s[0] = (s[0] & ~keepMask(len)) | (txt[i] & keepMask(len));
            end
            s[0] = s[0] ^ padBit(len);
            if (i == txt.size() - 1) begin
                s[1] = s[1] ^ key[127:64];
                s[2] = s[2] ^ key[63:0];
                s    = permute(s, 12);
            end else begin
                s = permute(s, 6);
            end
        end
        tag = {s[3], s[4]} ^ key;
    endtask

endpackage

// File: tests/ascon_assert.sv
`timescale 1ns/1ps

module asconAssert (
    input logic clk,
    input logic rst,
    input logic read,
    input logic outValid,
    input logic tagValid
);
    int errCount = 0;

    tagPulse: assert property (@(posedge clk) disable iff (rst) tagValid |=> !tagValid)
        else begin
            $error("tagValid stayed high for more than one cycle");
            errCount++;
        end

    outWithRead: assert property (@(posedge clk) disable iff (rst) outValid |-> read)
        else begin
            $error("outValid high without read");
            errCount++;
        end

    outOrTag: assert property (@(posedge clk) disable iff (rst) !(outValid && tagValid))
        else begin
            $error("outValid and tagValid high in the same cycle");
            errCount++;
        end

    // Strobes stay quiet while reset is held
    quietInReset: assert property (@(posedge clk) rst |-> !(read || outValid || tagValid))
        else begin
            $error("Strobe high during reset");
            errCount++;
        end

endmodule

bind asconTop asconAssert u_asconAssert (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .outValid(outValid),
    .tagValid(tagValid)
);

// File: tests/asconTb.sv
`timescale 1ns/1ps
`include "ascon_defs.svh"

module asconTb;
    import asconModelPkg::*;

    localparam int clkHalf        = 4;
    localparam int resetCycles    = 10;
    localparam int randomMessages = 8;
    // Fixed tests, then enc and dec of up to 6 blocks per random message
    localparam int totalBlocks    = 5 + 1 + 5 + 5 + randomMessages * 2 * 6;
    localparam int watchdogCycles = totalBlocks * 40 + 200;

    logic                        clk;
    logic                        rst;
    logic                        start;
    logic                        hasAd;
    logic                        enc;
    logic [`ASCON_KEY_BITS-1:0]  key;
    logic [`ASCON_KEY_BITS-1:0]  nonce;
    logic [`ASCON_WORD_BITS-1:0] adBlock;
    logic [`ASCON_LEN_BITS-1:0]  adLen;
    logic [`ASCON_WORD_BITS-1:0] textBlock;
    logic [`ASCON_LEN_BITS-1:0]  textLen;
    logic                        read;
    logic [`ASCON_WORD_BITS-1:0] outBlock;
    logic                        outValid;
    logic [`ASCON_KEY_BITS-1:0]  tag;
    logic                        tagValid;

    int seed = 32'h38fd;

    // Message of the first test, reused by the decryption tests
    logic [`ASCON_KEY_BITS-1:0] refKey;
    logic [`ASCON_KEY_BITS-1:0] refNonce;
    logic [`ASCON_KEY_BITS-1:0] refTag;
    blockQ                      refAd;
    blockQ                      refPlain;
    blockQ                      refCipher;

    asconTop u_asconTop (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .hasAd    (hasAd),
        .enc      (enc),
        .key      (key),
        .nonce    (nonce),
        .adBlock  (adBlock),
        .adLen    (adLen),
        .textBlock(textBlock),
        .textLen  (textLen),
        .read     (read),
        .outBlock (outBlock),
        .outValid (outValid),
        .tag      (tag),
        .tagValid (tagValid)
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic reportFail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic logic [`ASCON_WORD_BITS-1:0] blockAt(input blockQ q, input int idx);
        return (idx < q.size()) ? q[idx] : '0;
    endfunction

    function automatic logic [`ASCON_LEN_BITS-1:0] lenAt(input blockQ q, input int idx,
            input int lastLen);
        return (idx < q.size() - 1) ? 4'd8 : 4'(lastLen);
    endfunction

    function automatic blockQ maskLast(input blockQ q, input int lastLen);
        blockQ r;
        r = q;
        r[r.size() - 1] = r[r.size() - 1] & keepMask(lastLen);
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Message driver with read timing and count checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic runMessage(input logic encMode, input logic [127:0] k, n,
            input blockQ ad, input int adLast, input blockQ txt, input int txtLast,
            output blockQ res, output logic [127:0] gotTag);
        int adIdx;
        int txtIdx;
        int edgeNum;
        int lastEdge;
        int reads;
        bit finished;
        res = {};
        adIdx = 0;
        txtIdx = 0;
        edgeNum = 0;
        lastEdge = 1;
        reads = 0;
        finished = 1'b0;
        @(posedge clk);
        start     <= 1'b1;
        hasAd     <= (ad.size() > 0);
        enc       <= encMode;
        key       <= k;
        nonce     <= n;
        adBlock   <= blockAt(ad, 0);
        adLen     <= lenAt(ad, 0, adLast);
        textBlock <= blockAt(txt, 0);
        textLen   <= lenAt(txt, 0, txtLast);
        while (!finished) begin
            @(posedge clk);
            edgeNum++;
            start <= 1'b0;
            if (outValid) begin
                assert (read && adIdx >= ad.size())
                    else reportFail("outValid outside a text block read");
                res.push_back(outBlock);
            end
            if (read) begin
                reads++;
                assert (edgeNum - lastEdge == ((reads == 1) ? 6 : 3))
                    else reportFail($sformatf("read %0d came %0d cycles after the last event",
                                              reads, edgeNum - lastEdge));
                lastEdge = edgeNum;
                if (adIdx < ad.size()) begin
                    adIdx++;
                    adBlock <= blockAt(ad, adIdx);
                    adLen   <= lenAt(ad, adIdx, adLast);
                end else begin
                    txtIdx++;
                    textBlock <= blockAt(txt, txtIdx);
                    textLen   <= lenAt(txt, txtIdx, txtLast);
                end
            end
            if (tagValid) begin
                assert (edgeNum - lastEdge == 6)
                    else reportFail($sformatf("tagValid came %0d cycles after the last read",
                                              edgeNum - lastEdge));
                assert (reads == ad.size() + txt.size())
                    else reportFail($sformatf("%0d reads, expected %0d",
                                              reads, ad.size() + txt.size()));
                gotTag = tag;
                finished = 1'b1;
            end
        end
    endtask

    task automatic compareBlocks(input string what, input blockQ got, input blockQ exp);
        assert (got.size() == exp.size())
            else reportFail($sformatf("%s: %0d blocks, expected %0d", what, got.size(),
                                      exp.size()));
        foreach (exp[i]) begin
            assert (got[i] === exp[i])
                else reportFail($sformatf("%s block %0d: got %h, expected %h", what, i,
                                          got[i], exp[i]));
        end
    endtask

    task automatic compareTag(input string what, input logic [127:0] got, exp);
        assert (got === exp)
            else reportFail($sformatf("%s tag: got %h, expected %h", what, got, exp));
    endtask

    // DUT against the model for one message
    task automatic checkMessage(input logic encMode, input logic [127:0] k, n,
            input blockQ ad, input int adLast, input blockQ txt, input int txtLast,
            output blockQ res, output logic [127:0] tagOut);
        blockQ        expRes;
        logic [127:0] expTag;
        aeadModel(encMode, k, n, ad, adLast, txt, txtLast, expRes, expTag);
        runMessage(encMode, k, n, ad, adLast, txt, txtLast, res, tagOut);
        compareBlocks(encMode ? "ciphertext" : "plaintext", res, expRes);
        compareTag(encMode ? "encryption" : "decryption", tagOut, expTag);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testEncryptWithAd();
        refKey    = 128'h000102030405060708090a0b0c0d0e0f;
        refNonce  = 128'h101112131415161718191a1b1c1d1e1f;
        // Bytes past the length are junk on purpose
        refAd     = {64'h41445f626c6f636b, 64'h0011223344556677, 64'hdeadbeef01020304};
        refPlain  = {64'h506c61696e746578, 64'h7431323334aaaaaa};
        checkMessage(1'b1, refKey, refNonce, refAd, 3, refPlain, 5, refCipher, refTag);
    endtask

    task automatic testEncryptEmpty();
        blockQ        noAd;
        blockQ        txt;
        blockQ        res;
        logic [127:0] t;
        txt = {64'hffffffffffffffff};
        checkMessage(1'b1, 128'h0f0e0d0c0b0a09080706050403020100,
                     128'hcafef00d000000001234567800000000, noAd, 0, txt, 0, res, t);
    endtask

    task automatic testDecrypt();
        blockQ        res;
        logic [127:0] t;
        checkMessage(1'b0, refKey, refNonce, refAd, 3, refCipher, 5, res, t);
        compareBlocks("roundtrip", res, maskLast(refPlain, 5));
        compareTag("roundtrip", t, refTag);
    endtask

    task automatic testDecryptFlipped();
        blockQ        flipped;
        blockQ        res;
        logic [127:0] t;
        flipped = refCipher;
        flipped[0] = flipped[0] ^ 64'h0000ff0000000000;
        checkMessage(1'b0, refKey, refNonce, refAd, 3, flipped, 5, res, t);
        assert (t !== refTag)
            else reportFail("Tag of altered ciphertext equals the original tag");
    endtask

    task automatic testRandomRoundtrips();
        blockQ        ad;
        blockQ        txt;
        blockQ        ct;
        blockQ        pt;
        logic [127:0] k;
        logic [127:0] n;
        logic [127:0] encTag;
        logic [127:0] decTag;
        int           adLast;
        int           txtLast;
        int           nAd;
        int           nTxt;
        for (int m = 0; m < randomMessages; m++) begin
            k = {$random(seed), $random(seed), $random(seed), $random(seed)};
            n = {$random(seed), $random(seed), $random(seed), $random(seed)};
            nAd = $unsigned($random(seed)) % 4;
            nTxt = 1 + $unsigned($random(seed)) % 3;
            adLast = $unsigned($random(seed)) % 8;
            txtLast = $unsigned($random(seed)) % 8;
            ad = {};
            txt = {};
            repeat (nAd) ad.push_back({$random(seed), $random(seed)});
            repeat (nTxt) txt.push_back({$random(seed), $random(seed)});
            checkMessage(1'b1, k, n, ad, adLast, txt, txtLast, ct, encTag);
            checkMessage(1'b0, k, n, ad, adLast, ct, txtLast, pt, decTag);
            compareBlocks("random roundtrip", pt, maskLast(txt, txtLast));
            compareTag("random roundtrip", decTag, encTag);
        end
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        hasAd     = 1'b0;
        enc       = 1'b0;
        key       = '0;
        nonce     = '0;
        adBlock   = '0;
        adLen     = '0;
        textBlock = '0;
        textLen   = '0;
        repeat (resetCycles) @(posedge clk);
        assert (!read && !outValid && !tagValid && !u_asconTop.load && !u_asconTop.permDone)
            else reportFail("Strobes not low during reset");
        rst <= 1'b0;
        testEncryptWithAd();
        testEncryptEmpty();
        testDecrypt();
        testDecryptFlipped();
        testRandomRoundtrips();
        repeat (2) @(posedge clk);
        if (u_asconTop.u_asconAssert.errCount == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("[FAIL] %0t: %0d bound assertion failures", $time,
                     u_asconTop.u_asconAssert.errCount);
            $display("Something failed");
            $fatal(1, "Bound assertions failed");
        end
    end

endmodule

// File: sim.f
+incdir+source
source/asconAlgPkg.sv
source/asconCtrlPkg.sv
source/asconRound.sv
source/asconPermutation.sv
source/asconPadding.sv
source/asconController.sv
source/asconTop.sv
tests/asconModelPkg.sv
tests/ascon_assert.sv
tests/asconTb.sv

// File: Bender.yml
package:
  name: ascon

sources:
  - include_dirs:
      - source
    files:
      - source/asconAlgPkg.sv
      - source/asconCtrlPkg.sv
      - source/asconRound.sv
      - source/asconPermutation.sv
      - source/asconPadding.sv
      - source/asconController.sv
      - source/asconTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/asconModelPkg.sv
      - tests/ascon_assert.sv
      - tests/asconTb.sv
